/* src/bf_macros.svh */
`ifndef BF_MACROS_SVH
`define BF_MACROS_SVH

// --------------------
// Array sizes
// --------------------

// Beams formed per half
`define BF_BEAM 2

// Antennas per sample word, power of two
`define BF_ANT 4

// --------------------
// Data widths
// --------------------

// One antenna sample or codeword element, re in upper half
`define BF_IW 32

// Beam accumulator, full width and sign-extended
`define BF_OW 48

`endif

/* src/bf_sample_pkg.sv */
`include "bf_macros.svh"

package bf_sample_pkg;

    // --------------------
    // Complex sample
    // --------------------

    // Real part in the upper half of the word
    typedef struct packed {
        logic signed [15:0] re;
        logic signed [15:0] im;
    } cplx16_t;

    // --------------------
    // Antenna sample word
    // --------------------

    // Raw on buses and in copies
    // Complex view only at the multipliers
    typedef union packed {
        logic [`BF_IW-1:0] raw;
        cplx16_t           c;
    } ant_sample_u;

endpackage

/* src/bf_beam_pkg.sv */
`include "bf_macros.svh"

package bf_beam_pkg;

    // --------------------
    // Codeword element
    // --------------------

    // Same two views as a stream sample
    typedef union packed {
        logic [`BF_IW-1:0]      raw;
        bf_sample_pkg::cplx16_t c;
    } weight_u;

    // --------------------
    // Indexes and results
    // --------------------

    typedef logic [$clog2(`BF_BEAM)-1:0] beam_idx_t;
    typedef logic [$clog2(`BF_ANT)-1:0]  ant_idx_t;

    // Full-width beam sum, no rounding
    typedef logic signed [`BF_OW-1:0] beam_acc_t;

endpackage

/* src/codebook_regs.sv */
`include "bf_macros.svh"

module codebook_regs
    import bf_beam_pkg::*;
(
    input  logic                                     i_clk,
    input  logic                                     i_rst_n,
    // Codeword write port
    input  logic                                     i_cw_wr_en,
    input  logic                                     i_cw_wr_odd,
    input  beam_idx_t                                i_cw_wr_beam,
    input  ant_idx_t                                 i_cw_wr_ant,
    input  weight_u                                  i_cw_wr_data,
    // Stream in
    input  logic                                     i_valid,
    input  logic                                     i_sop,
    input  logic                                     i_eop,
    input  logic    [`BF_ANT-1:0][`BF_IW-1:0]        i_even_data,
    input  logic    [`BF_ANT-1:0][`BF_IW-1:0]        i_odd_data,
    // Stream out, one cycle later
    output logic                                     o_valid,
    output logic                                     o_sop,
    output logic                                     o_eop,
    output logic    [`BF_ANT-1:0][`BF_IW-1:0]        o_even_data,
    output logic    [`BF_ANT-1:0][`BF_IW-1:0]        o_odd_data,
    // Active banks
    output weight_u [`BF_BEAM-1:0][`BF_ANT-1:0]      o_cw_even,
    output weight_u [`BF_BEAM-1:0][`BF_ANT-1:0]      o_cw_odd
);

    weight_u [`BF_BEAM-1:0][`BF_ANT-1:0] shadow_even;
    weight_u [`BF_BEAM-1:0][`BF_ANT-1:0] shadow_odd;
    weight_u [`BF_BEAM-1:0][`BF_ANT-1:0] active_even;
    weight_u [`BF_BEAM-1:0][`BF_ANT-1:0] active_odd;

    // --------------------
    // Banks
    // --------------------

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            shadow_even <= '0;
            shadow_odd  <= '0;
            active_even <= '0;
            active_odd  <= '0;
        end else begin
            // Address decode into the shadow bank
            if (i_cw_wr_en) begin
                if (i_cw_wr_odd) begin
                    shadow_odd[i_cw_wr_beam][i_cw_wr_ant] <= i_cw_wr_data;
                end else begin
                    shadow_even[i_cw_wr_beam][i_cw_wr_ant] <= i_cw_wr_data;
                end
            end
            // Packet start, takes the shadow as it was before this edge
            if (i_valid && i_sop) begin
                active_even <= shadow_even;
                active_odd  <= shadow_odd;
            end
        end
    end

    // --------------------
    // Stream delay
    // --------------------

    // Markers, sop/eop only kept with valid
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
            o_sop   <= 1'b0;
            o_eop   <= 1'b0;
        end else begin
            o_valid <= i_valid;
            o_sop   <= i_valid & i_sop;
            o_eop   <= i_valid & i_eop;
        end
    end

    // Payload
    always_ff @(posedge i_clk) begin
        o_even_data <= i_even_data;
        o_odd_data  <= i_odd_data;
    end

    assign o_cw_even = active_even;
    assign o_cw_odd  = active_odd;

endmodule

/* src/mac_ants.sv */
`include "bf_macros.svh"

module mac_ants
    import bf_sample_pkg::*;
    import bf_beam_pkg::*;
#(
    parameter int ANT = `BF_ANT
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  ant_sample_u [ANT-1:0] i_ants_data,
    input  logic                  i_valid,
    input  logic                  i_sop,
    input  logic                  i_eop,
    input  weight_u     [ANT-1:0] i_code_word,
    output beam_acc_t             o_data_i,
    output beam_acc_t             o_data_q,
    output logic                  o_valid,
    output logic                  o_sop,
    output logic                  o_eop
);

    // Adder tree depth
    localparam int A   = $clog2(ANT);
    // Input reg, product reg, then A tree levels
    localparam int LAT = 2 + A;

    ant_sample_u [ANT-1:0] samp_q;
    weight_u     [ANT-1:0] cw_q;

    // Heap-ordered tree
    // Node n sums nodes 2n and 2n+1
    // Leaves ANT..2*ANT-1 hold products
    beam_acc_t node_re [1:2*ANT-1];
    beam_acc_t node_im [1:2*ANT-1];

    logic [LAT-1:0] vld_sr;
    logic [LAT-1:0] sop_sr;
    logic [LAT-1:0] eop_sr;

    // --------------------
    // Stage 0
    // --------------------

    // Samples and codeword registered together
    always_ff @(posedge i_clk) begin
        samp_q <= i_ants_data;
        cw_q   <= i_code_word;
    end

    // --------------------
    // Stage 1
    // --------------------

    // Full complex product per antenna
    // Operands widen to OW before the multiply
    for (genvar a = 0; a < ANT; a++) begin : g_prod
        always_ff @(posedge i_clk) begin
            node_re[ANT+a] <= samp_q[a].c.re * cw_q[a].c.re
                            - samp_q[a].c.im * cw_q[a].c.im;
            node_im[ANT+a] <= samp_q[a].c.re * cw_q[a].c.im
                            + samp_q[a].c.im * cw_q[a].c.re;
        end
    end

    // --------------------
    // Adder tree
    // --------------------

    // Level lv holds nodes 2^lv .. 2^(lv+1)-1
    // Root is node 1
    for (genvar lv = 0; lv < A; lv++) begin : g_level
        for (genvar n = (1 << lv); n < (2 << lv); n++) begin : g_node
            always_ff @(posedge i_clk) begin
                node_re[n] <= node_re[2*n] + node_re[2*n+1];
                node_im[n] <= node_im[2*n] + node_im[2*n+1];
            end
        end
    end

    // --------------------
    // Markers
    // --------------------

    // Same depth as the data path
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            vld_sr <= '0;
            sop_sr <= '0;
            eop_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[LAT-2:0], i_valid};
            sop_sr <= {sop_sr[LAT-2:0], i_valid & i_sop};
            eop_sr <= {eop_sr[LAT-2:0], i_valid & i_eop};
        end
    end

    assign o_data_i = node_re[1];
    assign o_data_q = node_im[1];
    assign o_valid  = vld_sr[LAT-1];
    assign o_sop    = sop_sr[LAT-1];
    assign o_eop    = eop_sr[LAT-1];

endmodule

/* src/mac_beams.sv */
`include "bf_macros.svh"

module mac_beams
    import bf_sample_pkg::*;
    import bf_beam_pkg::*;
#(
    parameter int BEAM = `BF_BEAM,
    parameter int ANT  = `BF_ANT
) (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    input  ant_sample_u [ANT-1:0]            i_ants_data_even,
    input  ant_sample_u [ANT-1:0]            i_ants_data_odd,
    input  logic                             i_valid,
    input  logic                             i_sop,
    input  logic                             i_eop,
    input  weight_u     [BEAM-1:0][ANT-1:0]  i_code_word_even,
    input  weight_u     [BEAM-1:0][ANT-1:0]  i_code_word_odd,
    // Per-half results
    output beam_acc_t   [BEAM-1:0]           o_data_even_i,
    output beam_acc_t   [BEAM-1:0]           o_data_even_q,
    output beam_acc_t   [BEAM-1:0]           o_data_odd_i,
    output beam_acc_t   [BEAM-1:0]           o_data_odd_q,
    // Even plus odd
    output beam_acc_t   [BEAM-1:0]           o_data_i,
    output beam_acc_t   [BEAM-1:0]           o_data_q,
    output logic                             o_valid,
    output logic                             o_sop,
    output logic                             o_eop
);

    beam_acc_t [BEAM-1:0] even_re;
    beam_acc_t [BEAM-1:0] even_im;
    beam_acc_t [BEAM-1:0] odd_re;
    beam_acc_t [BEAM-1:0] odd_im;

    // Markers of the even instances, all alike
    logic [BEAM-1:0] even_vld;
    logic [BEAM-1:0] even_sop;
    logic [BEAM-1:0] even_eop;

    // --------------------
    // Per-beam MACs
    // --------------------

    for (genvar b = 0; b < BEAM; b++) begin : g_beam
        mac_ants #(
            .ANT         (ANT)
        ) u_mac_even (
            .i_clk       (i_clk),
            .i_rst_n     (i_rst_n),
            .i_ants_data (i_ants_data_even),
            .i_valid     (i_valid),
            .i_sop       (i_sop),
            .i_eop       (i_eop),
            .i_code_word (i_code_word_even[b]),
            .o_data_i    (even_re[b]),
            .o_data_q    (even_im[b]),
            .o_valid     (even_vld[b]),
            .o_sop       (even_sop[b]),
            .o_eop       (even_eop[b])
        );

        // Odd markers match the even ones, left open
        mac_ants #(
            .ANT         (ANT)
        ) u_mac_odd (
            .i_clk       (i_clk),
            .i_rst_n     (i_rst_n),
            .i_ants_data (i_ants_data_odd),
            .i_valid     (i_valid),
            .i_sop       (i_sop),
            .i_eop       (i_eop),
            .i_code_word (i_code_word_odd[b]),
            .o_data_i    (odd_re[b]),
            .o_data_q    (odd_im[b]),
            .o_valid     (),
            .o_sop       (),
            .o_eop       ()
        );
    end

    // --------------------
    // Combine stage
    // --------------------

    // Sum and per-half copies in one register stage
    always_ff @(posedge i_clk) begin
        for (int b = 0; b < BEAM; b++) begin
            o_data_i[b]      <= even_re[b] + odd_re[b];
            o_data_q[b]      <= even_im[b] + odd_im[b];
            o_data_even_i[b] <= even_re[b];
            o_data_even_q[b] <= even_im[b];
            o_data_odd_i[b]  <= odd_re[b];
            o_data_odd_q[b]  <= odd_im[b];
        end
    end

    // Markers from beam 0 even
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
            o_sop   <= 1'b0;
            o_eop   <= 1'b0;
        end else begin
            o_valid <= even_vld[0];
            o_sop   <= even_sop[0];
            o_eop   <= even_eop[0];
        end
    end

endmodule

/* src/beamformer_top.sv */
`include "bf_macros.svh"

module beamformer_top
    import bf_sample_pkg::*;
    import bf_beam_pkg::*;
(
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    // Sample stream
    input  logic                            i_valid,
    input  logic                            i_sop,
    input  logic                            i_eop,
    input  ant_sample_u [`BF_ANT-1:0]       i_even_data,
    input  ant_sample_u [`BF_ANT-1:0]       i_odd_data,
    // Codeword write port
    input  logic                            i_cw_wr_en,
    input  logic                            i_cw_wr_odd,
    input  beam_idx_t                       i_cw_wr_beam,
    input  ant_idx_t                        i_cw_wr_ant,
    input  weight_u                         i_cw_wr_data,
    // Beams, 4+A cycles after the input
    output beam_acc_t   [`BF_BEAM-1:0]      o_data_even_i,
    output beam_acc_t   [`BF_BEAM-1:0]      o_data_even_q,
    output beam_acc_t   [`BF_BEAM-1:0]      o_data_odd_i,
    output beam_acc_t   [`BF_BEAM-1:0]      o_data_odd_q,
    output beam_acc_t   [`BF_BEAM-1:0]      o_data_i,
    output beam_acc_t   [`BF_BEAM-1:0]      o_data_q,
    output logic                            o_valid,
    output logic                            o_sop,
    output logic                            o_eop
);

    // Stream re-timed to meet the swapped bank
    logic                               dly_valid;
    logic                               dly_sop;
    logic                               dly_eop;
    ant_sample_u [`BF_ANT-1:0]          dly_even;
    ant_sample_u [`BF_ANT-1:0]          dly_odd;

    weight_u [`BF_BEAM-1:0][`BF_ANT-1:0] cw_even;
    weight_u [`BF_BEAM-1:0][`BF_ANT-1:0] cw_odd;

    // --------------------
    // Codebook
    // --------------------

    codebook_regs u_codebook_regs (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_cw_wr_en   (i_cw_wr_en),
        .i_cw_wr_odd  (i_cw_wr_odd),
        .i_cw_wr_beam (i_cw_wr_beam),
        .i_cw_wr_ant  (i_cw_wr_ant),
        .i_cw_wr_data (i_cw_wr_data),
        .i_valid      (i_valid),
        .i_sop        (i_sop),
        .i_eop        (i_eop),
        .i_even_data  (i_even_data),
        .i_odd_data   (i_odd_data),
        .o_valid      (dly_valid),
        .o_sop        (dly_sop),
        .o_eop        (dly_eop),
        .o_even_data  (dly_even),
        .o_odd_data   (dly_odd),
        .o_cw_even    (cw_even),
        .o_cw_odd     (cw_odd)
    );

    // --------------------
    // Beam MACs
    // --------------------

    mac_beams #(
        .BEAM             (`BF_BEAM),
        .ANT              (`BF_ANT)
    ) u_mac_beams (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_ants_data_even (dly_even),
        .i_ants_data_odd  (dly_odd),
        .i_valid          (dly_valid),
        .i_sop            (dly_sop),
        .i_eop            (dly_eop),
        .i_code_word_even (cw_even),
        .i_code_word_odd  (cw_odd),
        .o_data_even_i    (o_data_even_i),
        .o_data_even_q    (o_data_even_q),
        .o_data_odd_i     (o_data_odd_i),
        .o_data_odd_q     (o_data_odd_q),
        .o_data_i         (o_data_i),
        .o_data_q         (o_data_q),
        .o_valid          (o_valid),
        .o_sop            (o_sop),
        .o_eop            (o_eop)
    );

endmodule

/* testbench/tb_beamformer.sv */
`include "bf_macros.svh"

module tb_beamformer
    import bf_sample_pkg::*;
    import bf_beam_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int BEAM   = `BF_BEAM;
    localparam int ANT    = `BF_ANT;
    // Input to output, 4 + log2(ANT) cycles
    localparam int LAT    = 4 + $clog2(`BF_ANT);
    localparam int CLK_P  = 4;
    localparam int NROW   = 7;
    // One full codebook load, both halves
    localparam int CB_CYC = 2 * BEAM * ANT;

    typedef enum logic [1:0] {CB_UNIT, CB_ROTJ, CB_RAND, CB_KEEP} cb_mode_e;

    // One packet per row, wr_at is the word carrying a mid-packet write or -1
    typedef struct packed {
        cb_mode_e  mode;
        int        len;
        int        gap;
        int        wr_at;
        beam_acc_t exp_i;
        beam_acc_t exp_q;
    } row_t;

    typedef struct packed {
        longint                 due;
        int                     test;
        logic                   sop;
        logic                   eop;
        beam_acc_t [BEAM-1:0]   ei;
        beam_acc_t [BEAM-1:0]   eq;
        beam_acc_t [BEAM-1:0]   oi;
        beam_acc_t [BEAM-1:0]   oq;
        beam_acc_t [BEAM-1:0]   si;
        beam_acc_t [BEAM-1:0]   sq;
    } exp_t;

    // Known rows: fixed samples, written beam sums for every beam
    localparam row_t TBL [NROW] = '{
        '{CB_UNIT, 4, 3, -1, 48'sd1086, -48'sd136},
        '{CB_ROTJ, 3, 0, -1, 48'sd136, 48'sd1086},
        '{CB_RAND, 8, 0, 3, '0, '0},
        '{CB_KEEP, 5, 2, 0, '0, '0},
        '{CB_KEEP, 1, 4, -1, '0, '0},
        '{CB_RAND, 12, 0, 11, '0, '0},
        '{CB_KEEP, 6, 6, -1, '0, '0}
    };

    logic i_clk;
    logic i_rst_n;
    logic i_valid;
    logic i_sop;
    logic i_eop;
    ant_sample_u [ANT-1:0] i_even_data;
    ant_sample_u [ANT-1:0] i_odd_data;
    logic i_cw_wr_en;
    logic i_cw_wr_odd;
    beam_idx_t i_cw_wr_beam;
    ant_idx_t i_cw_wr_ant;
    weight_u i_cw_wr_data;
    beam_acc_t [BEAM-1:0] o_data_even_i;
    beam_acc_t [BEAM-1:0] o_data_even_q;
    beam_acc_t [BEAM-1:0] o_data_odd_i;
    beam_acc_t [BEAM-1:0] o_data_odd_q;
    beam_acc_t [BEAM-1:0] o_data_i;
    beam_acc_t [BEAM-1:0] o_data_q;
    logic o_valid;
    logic o_sop;
    logic o_eop;

    // Values for the next rising edge
    logic nx_valid;
    logic nx_sop;
    logic nx_eop;
    logic nx_we;
    logic nx_wr_odd;
    beam_idx_t nx_beam;
    ant_idx_t nx_ant;
    weight_u nx_wdata;
    ant_sample_u [ANT-1:0] nx_even_s;
    ant_sample_u [ANT-1:0] nx_odd_s;

    // Reference codebook, shadow and active
    weight_u [BEAM-1:0][ANT-1:0] sh_even;
    weight_u [BEAM-1:0][ANT-1:0] sh_odd;
    weight_u [BEAM-1:0][ANT-1:0] act_even;
    weight_u [BEAM-1:0][ANT-1:0] act_odd;

    exp_t exp_fifo[$];
    int cur_row;
    int cyc;
    int limit;
    int n_checks;
    int n_err;
    int test_err;

    beamformer_top u_beamformer_top (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_valid       (i_valid),
        .i_sop         (i_sop),
        .i_eop         (i_eop),
        .i_even_data   (i_even_data),
        .i_odd_data    (i_odd_data),
        .i_cw_wr_en    (i_cw_wr_en),
        .i_cw_wr_odd   (i_cw_wr_odd),
        .i_cw_wr_beam  (i_cw_wr_beam),
        .i_cw_wr_ant   (i_cw_wr_ant),
        .i_cw_wr_data  (i_cw_wr_data),
        .o_data_even_i (o_data_even_i),
        .o_data_even_q (o_data_even_q),
        .o_data_odd_i  (o_data_odd_i),
        .o_data_odd_q  (o_data_odd_q),
        .o_data_i      (o_data_i),
        .o_data_q      (o_data_q),
        .o_valid       (o_valid),
        .o_sop         (o_sop),
        .o_eop         (o_eop)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_P / 2) i_clk = ~i_clk;
    end

    // --------------------
    // Reference model
    // --------------------

    // (s.re + j s.im)(w.re + j w.im), no conjugate
    function automatic beam_acc_t dot_re(ant_sample_u [ANT-1:0] s, weight_u [ANT-1:0] w);
        longint acc;
        acc = 0;
        for (int a = 0; a < ANT; a++) begin
            acc += longint'(s[a].c.re) * longint'(w[a].c.re);
            acc -= longint'(s[a].c.im) * longint'(w[a].c.im);
        end
        return beam_acc_t'(acc);
    endfunction

    function automatic beam_acc_t dot_im(ant_sample_u [ANT-1:0] s, weight_u [ANT-1:0] w);
        longint acc;
        acc = 0;
        for (int a = 0; a < ANT; a++) begin
            acc += longint'(s[a].c.re) * longint'(w[a].c.im);
            acc += longint'(s[a].c.im) * longint'(w[a].c.re);
        end
        return beam_acc_t'(acc);
    endfunction

    // Unit weight is 1, rotation weight is j
    function automatic weight_u make_weight(cb_mode_e m);
        weight_u w;
        w.c.re = (m == CB_UNIT) ? 16'sd1 : 16'sd0;
        w.c.im = (m == CB_ROTJ) ? 16'sd1 : 16'sd0;
        if (m == CB_RAND) begin
            w.raw = $urandom;
        end
        return w;
    endfunction

    // Expected beams for the word about to be driven
    task automatic push_expected();
        exp_t e;
        e.due  = $time + LAT * CLK_P + CLK_P / 2;
        e.test = cur_row;
        e.sop  = nx_sop;
        e.eop  = nx_eop;
        for (int b = 0; b < BEAM; b++) begin
            e.ei[b] = dot_re(nx_even_s, act_even[b]);
            e.eq[b] = dot_im(nx_even_s, act_even[b]);
            e.oi[b] = dot_re(nx_odd_s, act_odd[b]);
            e.oq[b] = dot_im(nx_odd_s, act_odd[b]);
            e.si[b] = e.ei[b] + e.oi[b];
            e.sq[b] = e.eq[b] + e.oq[b];
            if (TBL[cur_row].mode == CB_UNIT || TBL[cur_row].mode == CB_ROTJ) begin
                e.si[b] = TBL[cur_row].exp_i;
                e.sq[b] = TBL[cur_row].exp_q;
            end
        end
        exp_fifo.push_back(e);
    endtask

    // --------------------
    // Stimulus
    // --------------------

    // Drive one cycle, then step the model in DUT order
    task automatic tick();
        @(posedge i_clk);
        i_valid      <= nx_valid;
        i_sop        <= nx_sop;
        i_eop        <= nx_eop;
        i_even_data  <= nx_even_s;
        i_odd_data   <= nx_odd_s;
        i_cw_wr_en   <= nx_we;
        i_cw_wr_odd  <= nx_wr_odd;
        i_cw_wr_beam <= nx_beam;
        i_cw_wr_ant  <= nx_ant;
        i_cw_wr_data <= nx_wdata;
        // Swap sees the shadow before this cycle's write
        if (nx_valid && nx_sop) begin
            act_even = sh_even;
            act_odd  = sh_odd;
        end
        if (nx_valid) begin
            push_expected();
        end
        if (nx_we && nx_wr_odd) begin
            sh_odd[nx_beam][nx_ant] = nx_wdata;
        end else if (nx_we) begin
            sh_even[nx_beam][nx_ant] = nx_wdata;
        end
    endtask

    task automatic load_codebook(cb_mode_e m);
        for (int h = 0; h < 2; h++) begin
            for (int b = 0; b < BEAM; b++) begin
                for (int a = 0; a < ANT; a++) begin
                    nx_we     = 1'b1;
                    nx_wr_odd = h[0];
                    nx_beam   = beam_idx_t'(b);
                    nx_ant    = ant_idx_t'(a);
                    nx_wdata  = make_weight(m);
                    tick();
                end
            end
        end
        nx_we = 1'b0;
    endtask

    task automatic fill_samples(cb_mode_e m);
        for (int a = 0; a < ANT; a++) begin
            if (m == CB_UNIT || m == CB_ROTJ) begin
                nx_even_s[a].c.re = 16'(100 * (a + 1));
                nx_even_s[a].c.im = 16'(7 * (a + 1));
                nx_odd_s[a].c.re  = 16'(20 + a);
                nx_odd_s[a].c.im  = 16'(-50 - a);
            end else begin
                nx_even_s[a].raw = $urandom;
                nx_odd_s[a].raw  = $urandom;
            end
        end
    endtask

    task automatic run_packet(int r);
        cur_row = r;
        if (TBL[r].mode != CB_KEEP) begin
            load_codebook(TBL[r].mode);
        end
        for (int w = 0; w < TBL[r].len; w++) begin
            fill_samples(TBL[r].mode);
            nx_valid = 1'b1;
            nx_sop   = (w == 0);
            nx_eop   = (w == TBL[r].len - 1);
            nx_we    = (w == TBL[r].wr_at);
            // Random address, lands in the shadow only
            if (nx_we) begin
                nx_wr_odd = 1'($urandom);
                nx_beam   = beam_idx_t'($urandom_range(BEAM - 1));
                nx_ant    = ant_idx_t'($urandom_range(ANT - 1));
                nx_wdata  = make_weight(CB_RAND);
            end
            tick();
        end
        nx_valid = 1'b0;
        nx_sop   = 1'b0;
        nx_eop   = 1'b0;
        nx_we    = 1'b0;
        repeat (TBL[r].gap) tick();
    endtask

    // --------------------
    // Checks
    // --------------------

    task automatic check_acc(string name, beam_acc_t exp, beam_acc_t act);
        n_checks++;
        if (act !== exp) begin
            n_err++;
            test_err++;
            $display("MISMATCH time=%0d ns %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        n_checks++;
        if (act !== exp) begin
            n_err++;
            test_err++;
            $display("MISMATCH time=%0d ns %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_outputs(exp_t e);
        if (e.sop) begin
            test_err = 0;
        end
        check_flag("o_valid", 1'b1, o_valid);
        check_flag("o_sop", e.sop, o_sop);
        check_flag("o_eop", e.eop, o_eop);
        for (int b = 0; b < BEAM; b++) begin
            check_acc($sformatf("o_data_even_i[%0d]", b), e.ei[b], o_data_even_i[b]);
            check_acc($sformatf("o_data_even_q[%0d]", b), e.eq[b], o_data_even_q[b]);
            check_acc($sformatf("o_data_odd_i[%0d]", b), e.oi[b], o_data_odd_i[b]);
            check_acc($sformatf("o_data_odd_q[%0d]", b), e.oq[b], o_data_odd_q[b]);
            check_acc($sformatf("o_data_i[%0d]", b), e.si[b], o_data_i[b]);
            check_acc($sformatf("o_data_q[%0d]", b), e.sq[b], o_data_q[b]);
        end
        if (e.eop) begin
            $display("test %0d (%s, %0d words): %0d errors", e.test,
                     TBL[e.test].mode.name(), TBL[e.test].len, test_err);
        end
    endtask

    // Sampled mid-cycle, away from the driving edge
    always @(negedge i_clk) begin
        cyc++;
        if (cyc > limit) begin
            $display("Timeout after %0d cycles, %0d outputs never arrived",
                     cyc, exp_fifo.size());
            $display("CHECKS FAILED");
            $finish;
        end else if (exp_fifo.size() != 0 && exp_fifo[0].due == $time) begin
            check_outputs(exp_fifo.pop_front());
        end else begin
            // Reset, gaps and anything between expected words
            check_flag("o_valid", 1'b0, o_valid);
        end
    end

    // --------------------
    // Main sequence
    // --------------------

    initial begin
        void'($urandom(32'hf04a));
        i_rst_n      = 1'b0;
        i_valid      = 1'b0;
        i_sop        = 1'b0;
        i_eop        = 1'b0;
        i_even_data  = '0;
        i_odd_data   = '0;
        i_cw_wr_en   = 1'b0;
        i_cw_wr_odd  = 1'b0;
        i_cw_wr_beam = '0;
        i_cw_wr_ant  = '0;
        i_cw_wr_data = '0;
        {nx_valid, nx_sop, nx_eop, nx_we, nx_wr_odd} = '0;
        nx_beam   = '0;
        nx_ant    = '0;
        nx_wdata  = '0;
        nx_even_s = '0;
        nx_odd_s  = '0;
        sh_even   = '0;
        sh_odd    = '0;
        act_even  = '0;
        act_odd   = '0;
        cur_row   = 0;
        // Reset, settle, every row, drain, plus margin
        limit = 16 + 2 + LAT + 32;
        for (int r = 0; r < NROW; r++) begin
            limit += TBL[r].len + TBL[r].gap + ((TBL[r].mode != CB_KEEP) ? CB_CYC : 0);
        end
        repeat (16) @(posedge i_clk);
        i_rst_n <= 1'b1;
        repeat (2) tick();
        for (int r = 0; r < NROW; r++) begin
            run_packet(r);
        end
        while (exp_fifo.size() != 0) begin
            @(posedge i_clk);
        end
        repeat (4) @(negedge i_clk);
        $display("checks: %0d, errors: %0d", n_checks, n_err);
        if (n_err == 0 && n_checks > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+src
src/bf_sample_pkg.sv
src/bf_beam_pkg.sv
src/codebook_regs.sv
src/mac_ants.sv
src/mac_beams.sv
src/beamformer_top.sv
testbench/tb_beamformer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the beamformer testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
    -f sim.f --top-module tb_beamformer --Mdir obj_dir -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat build.log; echo "Build or simulation run returned an error"; exit 1; }

cat sim.log

# Pass only if the testbench printed its pass line
grep -qx "ALL CHECKS PASSED" sim.log && exit 0 || exit 1
